//--- filelist.f
icache_pkg.sv
icache_ctrl.sv
icache_tagv.sv
icache_data.sv
icache_way_select.sv
icache_top.sv
icache_properties.sv
icache_checker.sv
tb_icache.sv

//--- tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam int          NUM_REQ     = 400;
    localparam int          CYCLE_LIMIT = NUM_REQ * 12;
    localparam logic [31:0] SEED        = 32'hb3b5_f233;
    localparam logic [31:0] LFSR_MASK   = 32'h8020_0003;
    localparam logic [31:0] DATA_KEY    = 32'h5a5a_0f0f;
    // few indices, three tags each, so two ways keep evicting
    localparam logic [7:0]  INDEX_POOL [4] = '{8'h00, 8'h37, 8'hc5, 8'hff};
    localparam logic [19:0] TAG_POOL [3]   = '{20'h00000, 20'h1a2b3, 20'hfffff};

    logic                     clk;
    logic                     reset;
    logic                     valid;
    icache_pkg::icache_addr_u cpu_addr;
    logic                     addr_ok;
    logic                     data_ok;
    logic [31:0]              rdata;
    logic                     rd_req;
    logic [31:0]              rd_addr;
    logic                     rd_rdy;
    logic                     ret_valid;
    icache_pkg::icache_line_t ret_data;
    int                       value_errors;
    int                       protocol_errors;
    int                       accepted;
    int                       answered;
    int                       run_errors;
    int                       cycles;
    logic [31:0]              lfsr;

    icache_top UUT (.*);

    icache_checker u_checker (.*);

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic pick_address(output icache_pkg::icache_addr_u a);
        logic [31:0] r;
        a.raw = '0;
        draw_bits(2, r);
        a.f.index = INDEX_POOL[r[1:0]];
        draw_bits(2, r);
        a.f.tag = TAG_POOL[r[1:0] % 3];
        draw_bits(2, r);
        a.f.offset.word = r[1:0];
    endtask

    function automatic icache_pkg::icache_line_t memory_line(input logic [31:0] line_addr);
        icache_pkg::icache_line_t line;
        for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++)
            line[w*32 +: 32] = (line_addr + 32'(w * 4)) ^ DATA_KEY;
        return line;
    endfunction

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d requests answered",
                     cycles, answered, NUM_REQ);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] seen_addr;
        logic [31:0] pending_addr;
        logic        took;
        logic        handshake;
        logic        req_seen;
        logic        rdy_armed;
        logic        ret_pending;
        int          rdy_wait;
        int          ret_wait;
        int          sent;
        lfsr        = SEED;
        sent        = 0;
        rdy_armed   = 1'b0;
        ret_pending = 1'b0;
        rdy_wait    = 0;
        ret_wait    = 0;
        reset       = 1'b1;
        valid       = 1'b0;
        cpu_addr    = '0;
        rd_rdy      = 1'b0;
        ret_valid   = 1'b0;
        ret_data    = '0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        while (sent < NUM_REQ || valid || answered < accepted) begin
            @(negedge clk);
            took      = valid && addr_ok;
            handshake = rd_req && rd_rdy;
            req_seen  = rd_req;
            seen_addr = rd_addr;
            @(posedge clk);
            #1;
            // CPU side
            if (took) begin
                valid = 1'b0;
                sent++;
            end
            if (!valid && sent < NUM_REQ) begin
                draw_bits(2, r);
                if (r[1:0] != 2'b00) begin
                    pick_address(cpu_addr);
                    valid = 1'b1;
                end
            end
            // memory responder
            ret_valid = 1'b0;
            if (handshake) begin
                rd_rdy       = 1'b0;
                pending_addr = seen_addr;
                draw_bits(2, r);
                ret_wait    = int'(r[1:0]) + 1;
                ret_pending = 1'b1;
            end else if (ret_pending) begin
                ret_wait--;
                if (ret_wait == 0) begin
                    ret_valid   = 1'b1;
                    ret_data    = memory_line(pending_addr);
                    ret_pending = 1'b0;
                end
            end else if (req_seen && !rd_rdy) begin
                if (!rdy_armed) begin
                    draw_bits(2, r);
                    rdy_wait  = int'(r[1:0]);
                    rdy_armed = 1'b1;
                end
                if (rdy_wait == 0) begin
                    rd_rdy    = 1'b1;
                    rdy_armed = 1'b0;
                end else begin
                    rdy_wait--;
                end
            end
        end
        repeat (4) @(posedge clk);  // catch late strays
        if (accepted != NUM_REQ || answered != accepted) begin
            $display("%0d requests accepted and %0d answered, %0d sent",
                     accepted, answered, NUM_REQ);
            run_errors++;
        end
        $display("errors: value %0d, protocol %0d, assertion %0d, run %0d",
                 value_errors, protocol_errors, UUT.u_properties.failures, run_errors);
        if (value_errors + protocol_errors + UUT.u_properties.failures + run_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- icache_checker.sv
`timescale 1ns/1ps
`default_nettype none

module icache_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  icache_pkg::icache_addr_u cpu_addr,
    input  logic                     addr_ok,
    input  logic                     data_ok,
    input  logic [31:0]              rdata,
    input  logic                     rd_req,
    input  logic [31:0]              rd_addr,
    input  logic                     rd_rdy,
    output int                       value_errors,
    output int                       protocol_errors,
    output int                       accepted,
    output int                       answered
);

    logic [icache_pkg::TAG_W-1:0] m_tag [icache_pkg::WAYS][icache_pkg::SETS];
    logic [icache_pkg::WAYS-1:0]  m_valid [icache_pkg::SETS];
    logic                         m_lru [icache_pkg::SETS];
    logic [31:0]                  addr_q [$];  // accepted, not yet answered
    int                           when_q [$];
    logic                         hit_q [$];
    int                           cycle;
    int                           reads;  // memory reads for the oldest request
    logic                         after_reset;

    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0f0f;
    endfunction

    // looks up the model and applies the refill and lru update right away
    function automatic logic model_hit(input icache_pkg::icache_addr_u a);
        logic [icache_pkg::INDEX_W-1:0] i;
        logic                           way;
        logic                           hit;
        i   = a.f.index;
        hit = 1'b0;
        way = m_lru[i];
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (m_valid[i][w] && m_tag[w][i] == a.f.tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            if (!m_valid[i][0])
                way = 1'b0;
            else if (!m_valid[i][1])
                way = 1'b1;
            m_tag[way][i]   = a.f.tag;
            m_valid[i][way] = 1'b1;
        end
        m_lru[i] = !way;  // other way is now lru
        return hit;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    always @(negedge clk) begin : sample
        logic [31:0] head;
        logic        head_hit;
        int          head_when;
        cycle++;
        if (reset) begin
            foreach (m_lru[s]) begin
                m_valid[s] = '0;
                m_lru[s]   = 1'b0;
            end
            addr_q.delete();
            when_q.delete();
            hit_q.delete();
            reads       = 0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                compare("rd_req", 0, rd_req);
                compare("data_ok", 0, data_ok);
                compare("addr_ok", 1, addr_ok);
                after_reset = 1'b0;
            end
            if (data_ok)
                answered++;
            if (data_ok && addr_q.size() == 0) begin
                $display("%0t: data_ok came with no request outstanding", $time);
                protocol_errors++;
            end else if (data_ok) begin
                head      = addr_q.pop_front();
                head_hit  = hit_q.pop_front();
                head_when = when_q.pop_front();
                compare("rdata", expected_word(head), rdata);
                if (head_hit && (cycle != head_when + 1 || reads != 0)) begin
                    $display("%0t: hit on %h took %0d cycles and %0d memory reads",
                             $time, head, cycle - head_when, reads);
                    protocol_errors++;
                end
                if (!head_hit && reads != 1) begin
                    $display("%0t: miss on %h made %0d memory reads instead of one",
                             $time, head, reads);
                    protocol_errors++;
                end
                reads = 0;
            end
            if (rd_req && rd_rdy) begin
                reads++;
                if (addr_q.size() == 0) begin
                    $display("%0t: memory read with no request outstanding", $time);
                    protocol_errors++;
                end else begin
                    compare("rd_addr", {addr_q[0][31:4], 4'h0}, rd_addr);
                end
            end
            if (valid && addr_ok) begin
                addr_q.push_back(cpu_addr.raw);
                when_q.push_back(cycle);
                hit_q.push_back(model_hit(cpu_addr));
                accepted++;
            end
        end
    end

endmodule

`default_nettype wire

//--- icache_properties.sv
`timescale 1ns/1ps
`default_nettype none

module icache_properties (
    input logic        clk,
    input logic        reset,
    input logic        valid,
    input logic        addr_ok,
    input logic        data_ok,
    input logic        rd_req,
    input logic [31:0] rd_addr,
    input logic        rd_rdy
);

    int outstanding;  // accepted and not yet answered
    int failures;

    always_ff @(posedge clk) begin
        if (reset)
            outstanding <= 0;
        else
            outstanding <= outstanding + int'(valid && addr_ok) - int'(data_ok);
    end

    rd_req_held: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req && $stable(rd_addr))
    else begin
        $error("rd_req dropped or rd_addr moved before rd_rdy");
        failures++;
    end

    data_ok_owed: assert property (@(posedge clk) disable iff (reset)
        data_ok |-> outstanding > 0)
    else begin
        $error("data_ok with no request outstanding");
        failures++;
    end

    no_accept_in_miss: assert property (@(posedge clk) disable iff (reset)
        rd_req |-> !addr_ok)
    else begin
        $error("addr_ok high during a memory read");
        failures++;
    end

endmodule

bind icache_top icache_properties u_properties (
    .clk     (clk),
    .reset   (reset),
    .valid   (valid),
    .addr_ok (addr_ok),
    .data_ok (data_ok),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_rdy  (rd_rdy)
);

`default_nettype wire

//--- icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     valid,
    input  icache_pkg::icache_addr_u cpu_addr,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [31:0]              rdata,
    output logic                     rd_req,
    output logic [31:0]              rd_addr,
    input  logic                     rd_rdy,
    input  logic                     ret_valid,
    input  icache_pkg::icache_line_t ret_data
);

    logic                           rd_en;
    logic [icache_pkg::INDEX_W-1:0] rd_index;
    logic                           hit;
    logic                           victim;
    logic                           lookup_done;
    logic [1:0]                     lookup_word;
    icache_pkg::icache_refill_t     refill;
    icache_pkg::icache_tagv_t       way_tagv [icache_pkg::WAYS];
    icache_pkg::icache_line_t       way_line [icache_pkg::WAYS];

    icache_ctrl u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .valid       (valid),
        .cpu_addr    (cpu_addr),
        .hit         (hit),
        .victim      (victim),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .rd_rdy      (rd_rdy),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .rd_index    (rd_index),
        .lookup_done (lookup_done),
        .refill      (refill),
        .lookup_word (lookup_word)
    );

    icache_tagv u_tagv (
        .clk      (clk),
        .reset    (reset),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .refill   (refill),
        .way_tagv (way_tagv)
    );

    icache_data u_data (
        .clk      (clk),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .refill   (refill),
        .way_line (way_line)
    );

    // refill tag and index always carry the buffered request
    icache_way_select u_way_select (
        .clk          (clk),
        .reset        (reset),
        .lookup_tag   (refill.tag),
        .lookup_index (refill.index),
        .lookup_word  (lookup_word),
        .way_tagv     (way_tagv),
        .way_line     (way_line),
        .lookup_done  (lookup_done),
        .refill       (refill),
        .hit          (hit),
        .rdata        (rdata),
        .victim       (victim)
    );

endmodule

`default_nettype wire

//--- icache_way_select.sv
`timescale 1ns/1ps
`default_nettype none

module icache_way_select (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [icache_pkg::TAG_W-1:0]   lookup_tag,
    input  logic [icache_pkg::INDEX_W-1:0] lookup_index,
    input  logic [1:0]                     lookup_word,
    input  icache_pkg::icache_tagv_t       way_tagv [icache_pkg::WAYS],
    input  icache_pkg::icache_line_t       way_line [icache_pkg::WAYS],
    input  logic                           lookup_done,
    input  icache_pkg::icache_refill_t     refill,
    output logic                           hit,
    output logic [31:0]                    rdata,
    output logic                           victim
);

    logic [icache_pkg::SETS-1:0] lru;  // least recently used way of each set
    logic [icache_pkg::WAYS-1:0] hit_way;

    for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_cmp
        assign hit_way[w] = way_tagv[w].valid && (way_tagv[w].tag == lookup_tag);
    end

    assign hit = |hit_way;

    // and-or mux over the ways
    always_comb begin
        rdata = '0;
        for (int w = 0; w < icache_pkg::WAYS; w++) begin
            if (hit_way[w])
                rdata = rdata | way_line[w][lookup_word*32 +: 32];
        end
    end

    // invalid way first, way 0 before way 1
    always_comb begin
        if (!way_tagv[0].valid)
            victim = 1'b0;
        else if (!way_tagv[1].valid)
            victim = 1'b1;
        else
            victim = lru[lookup_index];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (lookup_done) begin
            lru[lookup_index] <= hit_way[0];  // the other way becomes lru
        end else if (|refill.we) begin
            lru[refill.index] <= refill.we[0];
        end
    end

endmodule

`default_nettype wire

//--- icache_data.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data (
    input  logic                           clk,
    input  logic                           rd_en,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    input  icache_pkg::icache_refill_t     refill,
    output icache_pkg::icache_line_t       way_line [icache_pkg::WAYS]
);

    for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
        for (genvar b = 0; b < icache_pkg::WORDS_PER_LINE; b++) begin : g_bank
            logic [31:0] bank [icache_pkg::SETS];
            logic [31:0] word_q;

            // whole line lands at once, all banks of the way together
            always_ff @(posedge clk) begin
                if (refill.we[w])
                    bank[refill.index] <= refill.line[b*32 +: 32];
                if (rd_en)
                    word_q <= bank[rd_index];
            end

            assign way_line[w][b*32 +: 32] = word_q;
        end
    end

endmodule

`default_nettype wire

//--- icache_tagv.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tagv (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           rd_en,
    input  logic [icache_pkg::INDEX_W-1:0] rd_index,
    input  icache_pkg::icache_refill_t     refill,
    output icache_pkg::icache_tagv_t       way_tagv [icache_pkg::WAYS]
);

    for (genvar w = 0; w < icache_pkg::WAYS; w++) begin : g_way
        logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::SETS];
        logic [icache_pkg::SETS-1:0]  valid_bits;  // flops, cleared in one cycle
        logic [icache_pkg::TAG_W-1:0] tag_q;
        logic                         valid_q;

        // tag ram, synchronous read
        always_ff @(posedge clk) begin
            if (refill.we[w])
                tag_mem[refill.index] <= refill.tag;
            if (rd_en)
                tag_q <= tag_mem[rd_index];
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                valid_bits <= '0;
                valid_q    <= 1'b0;
            end else begin
                if (refill.we[w])
                    valid_bits[refill.index] <= 1'b1;
                if (rd_en)
                    valid_q <= valid_bits[rd_index];
            end
        end

        assign way_tagv[w] = '{tag: tag_q, valid: valid_q};
    end

endmodule

`default_nettype wire

//--- icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           valid,
    input  icache_pkg::icache_addr_u       cpu_addr,
    input  logic                           hit,
    input  logic                           victim,
    input  logic                           ret_valid,
    input  icache_pkg::icache_line_t       ret_data,
    input  logic                           rd_rdy,
    output logic                           addr_ok,
    output logic                           data_ok,
    output logic                           rd_req,
    output logic [31:0]                    rd_addr,
    output logic                           rd_en,
    output logic [icache_pkg::INDEX_W-1:0] rd_index,
    output logic                           lookup_done,
    output icache_pkg::icache_refill_t     refill,
    output logic [1:0]                     lookup_word
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS,
        REFILL,
        REPLAY
    } state_t;

    state_t                   state;
    state_t                   state_next;
    icache_pkg::icache_req_t  req_q;
    icache_pkg::icache_addr_u line_addr;
    logic                     victim_q;
    logic                     lookup_hit;
    logic                     accept;

    assign lookup_hit = (state == LOOKUP) && req_q.valid && hit;
    assign accept     = valid && addr_ok;

    assign addr_ok     = (state == IDLE) || lookup_hit; // hit frees the slot this cycle
    assign data_ok     = lookup_hit;
    assign lookup_done = lookup_hit;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (accept)
                    state_next = LOOKUP;
            end
            LOOKUP: begin
                if (!lookup_hit)
                    state_next = MISS;
                else if (!accept)
                    state_next = IDLE;
            end
            MISS: begin
                if (rd_rdy)
                    state_next = REFILL;
            end
            REFILL: begin
                if (ret_valid)
                    state_next = REPLAY;
            end
            REPLAY: begin
                state_next = LOOKUP;  // re-read of the filled set
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (reset) begin
            req_q.valid <= 1'b0;
        end else if (accept) begin
            req_q <= '{valid: 1'b1, addr: cpu_addr};
        end else if (lookup_hit) begin
            req_q.valid <= 1'b0;
        end
    end

    // victim of the missed set, held until the line returns
    always_ff @(posedge clk) begin
        if (state == LOOKUP && !lookup_hit)
            victim_q <= victim;
    end

    // array read: new address on accept, buffered one on replay
    assign rd_en    = accept || (state == REPLAY);
    assign rd_index = (state == REPLAY) ? req_q.addr.f.index : cpu_addr.f.index;

    always_comb begin
        line_addr          = req_q.addr;
        line_addr.f.offset = '0;
    end

    assign rd_req  = (state == MISS);
    assign rd_addr = line_addr.raw;

    always_comb begin
        refill.we = '0;
        if (state == REFILL && ret_valid)
            refill.we[victim_q] = 1'b1;
        refill.index = req_q.addr.f.index;  // tag and index also feed the compare
        refill.tag   = req_q.addr.f.tag;
        refill.line  = ret_data;
    end

    assign lookup_word = req_q.addr.f.offset.word;

endmodule

`default_nettype wire

//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int TAG_W          = 20;
    localparam int INDEX_W        = 8;
    localparam int OFFSET_W       = 4;
    localparam int SETS           = 256;
    localparam int WAYS           = 2;
    localparam int WORDS_PER_LINE = 4;

    localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

    typedef logic [WORDS_PER_LINE*32-1:0] icache_line_t;

    typedef struct packed {
        logic [WORD_SEL_W-1:0]          word;
        logic [OFFSET_W-WORD_SEL_W-1:0] byte_sel;
    } icache_offset_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
        icache_offset_t     offset;
    } icache_addr_fields_t;

    // flat word for the bus, split fields for lookup
    typedef union packed {
        logic [31:0]         raw;
        icache_addr_fields_t f;
    } icache_addr_u;

    typedef struct packed {
        logic         valid;
        icache_addr_u addr;
    } icache_req_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic             valid;
    } icache_tagv_t;

    typedef struct packed {
        logic [WAYS-1:0]    we;    // one-hot on the victim way
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        icache_line_t       line;
    } icache_refill_t;

endpackage

`default_nettype wire
